/* design/lsu_pkg.sv */
// ========================================
// Shared widths, bank count and opcode type for the load/store unit.
// Imported by every RTL module of the unit.
// ========================================
`default_nettype none

package lsu_pkg;

	localparam int WORD_BITS      = 16;
	localparam int LDM_ADDR_BITS  = 6;   // word address inside one bank
	localparam int LDM_NUM_BITS   = 2;   // bank field
	localparam int LDM_NUM        = 4;
	localparam int FULL_ADDR_BITS = LDM_NUM_BITS + LDM_ADDR_BITS;
	localparam int HOST_WR_BANKS  = 2;   // host may write banks below this index

	// configuration opcode, only EXE_ADD matters to this unit
	typedef enum logic [2:0] {
		OP_NOP      = 3'd0,
		OP_EXE_ADD  = 3'd1,
		OP_EXE_MUL  = 3'd2,
		OP_EXE_PASS = 3'd3
	} alu_op_e;

	typedef logic signed [WORD_BITS-1:0] word_t;

endpackage

`default_nettype wire

/* design/ldm_bank.sv */
// ========================================
// One local data memory bank, two ports, 64 x 16 bit.
// Reads return registered data one edge after the request.
// ========================================
`default_nettype none

module ldm_bank import lsu_pkg::*; (
	input  logic                     CLK,
	input  logic                     en_a,
	input  logic                     we_a,
	input  logic [LDM_ADDR_BITS-1:0] addr_a,
	input  word_t                    wdata_a,
	input  logic                     en_b,
	input  logic                     we_b,
	input  logic [LDM_ADDR_BITS-1:0] addr_b,
	input  word_t                    wdata_b,
	output word_t                    rdata_a,
	output word_t                    rdata_b
);

	word_t mem [0:(1 << LDM_ADDR_BITS)-1];

	// both ports in one process, port b lands last on a clash
	always_ff @(posedge CLK) begin
		if (en_a) begin
			if (we_a) begin
				mem[addr_a] <= wdata_a;
			end else begin
				rdata_a <= mem[addr_a];  // held while port idle
			end
		end
		if (en_b) begin
			if (we_b) begin
				mem[addr_b] <= wdata_b;
			end else begin
				rdata_b <= mem[addr_b];
			end
		end
	end

endmodule

`default_nettype wire

/* design/ldm_port_router.sv */
// ========================================
// Bank decode and fixed-priority arbitration for both bank ports.
// Port A serves host over controller A, port B serves ALU over controller B.
// ========================================
`default_nettype none

module ldm_port_router import lsu_pkg::*; (
	input  logic [FULL_ADDR_BITS-1:0]                host_addr,
	input  word_t                                    host_wdata,
	input  logic                                     host_en,
	input  logic                                     host_we,
	input  logic [FULL_ADDR_BITS-1:0]                ctrl_addr_a,
	input  logic                                     ctrl_en_a,
	input  logic [FULL_ADDR_BITS-1:0]                ctrl_addr_b,
	input  logic                                     ctrl_en_b,
	input  logic [FULL_ADDR_BITS-1:0]                alu_addr,
	input  word_t                                    alu_wdata,
	input  logic                                     alu_en,
	input  logic                                     alu_we,
	input  alu_op_e                                  cfg_op,
	output logic [LDM_NUM-1:0]                       bank_en_a,
	output logic [LDM_NUM-1:0]                       bank_we_a,
	output logic [LDM_NUM-1:0][LDM_ADDR_BITS-1:0]    bank_addr_a,
	output word_t [LDM_NUM-1:0]                      bank_wdata_a,
	output logic [LDM_NUM-1:0]                       bank_en_b,
	output logic [LDM_NUM-1:0]                       bank_we_b,
	output logic [LDM_NUM-1:0][LDM_ADDR_BITS-1:0]    bank_addr_b,
	output word_t [LDM_NUM-1:0]                      bank_wdata_b,
	output logic                                     ctrl_a_grant,
	output logic                                     ctrl_b_grant,
	output logic                                     host_grant
);

	logic [LDM_NUM_BITS-1:0]  host_bank, ctrl_bank_a, ctrl_bank_b, alu_bank;
	logic [LDM_ADDR_BITS-1:0] host_word, ctrl_word_a, ctrl_word_b, alu_word;
	logic [LDM_NUM-1:0]       host_hit, ctrl_a_hit, ctrl_b_hit, alu_hit;
	logic [LDM_NUM-1:0]       host_win, ctrl_a_win, ctrl_a_use, ctrl_b_win;
	logic                     exe_add_rd;  // bank 3 port A forced to controller

	assign {host_bank, host_word}     = host_addr;
	assign {ctrl_bank_a, ctrl_word_a} = ctrl_addr_a;
	assign {ctrl_bank_b, ctrl_word_b} = ctrl_addr_b;
	assign {alu_bank, alu_word}       = alu_addr;

	assign exe_add_rd = (cfg_op == OP_EXE_ADD) && ctrl_en_a;

	always_comb begin
		for (int k = 0; k < LDM_NUM; k++) begin
			host_hit[k]   = host_en && (host_bank == LDM_NUM_BITS'(k));
			ctrl_a_hit[k] = ctrl_en_a && (ctrl_bank_a == LDM_NUM_BITS'(k));
			ctrl_b_hit[k] = ctrl_en_b && (ctrl_bank_b == LDM_NUM_BITS'(k));
			alu_hit[k]    = alu_en && (alu_bank == LDM_NUM_BITS'(k));

			// EXE_ADD override takes the last bank away from the host
			host_win[k]   = host_hit[k] && !(exe_add_rd && (k == LDM_NUM-1));
			ctrl_a_win[k] = ctrl_a_hit[k] && !host_win[k];
			ctrl_a_use[k] = ctrl_a_win[k] || (exe_add_rd && (k == LDM_NUM-1));
			ctrl_b_win[k] = ctrl_b_hit[k] && !alu_hit[k];

			bank_en_a[k]    = host_win[k] || ctrl_a_use[k];
			bank_we_a[k]    = host_win[k] && host_we && (k < HOST_WR_BANKS);
			bank_addr_a[k]  = host_win[k] ? host_word : ctrl_word_a;
			bank_wdata_a[k] = host_wdata;

			bank_en_b[k]    = alu_hit[k] || ctrl_b_win[k];
			bank_we_b[k]    = alu_hit[k] && alu_we;
			bank_addr_b[k]  = alu_hit[k] ? alu_word : ctrl_word_b;
			bank_wdata_b[k] = alu_wdata;
		end
	end

	assign host_grant   = |host_win;
	assign ctrl_a_grant = |ctrl_a_win;  // won the bank its own field names
	assign ctrl_b_grant = |ctrl_b_win;

endmodule

`default_nettype wire

/* design/pixel_read_steer.sv */
// ========================================
// Steers registered bank data onto the pixel and host outputs.
// Grants and bank fields are captured with the request, data muxed a cycle later.
// ========================================
`default_nettype none

module pixel_read_steer import lsu_pkg::*; (
	input  logic                    CLK,
	input  logic                    RST,
	input  word_t [LDM_NUM-1:0]     bank_rdata_a,
	input  word_t [LDM_NUM-1:0]     bank_rdata_b,
	input  logic [LDM_NUM_BITS-1:0] ctrl_bank_a,
	input  logic [LDM_NUM_BITS-1:0] ctrl_bank_b,
	input  logic [LDM_NUM_BITS-1:0] host_bank,
	input  logic                    ctrl_a_grant,
	input  logic                    ctrl_b_grant,
	input  logic                    host_grant,
	input  alu_op_e                 cfg_op,
	input  logic                    stride,
	input  logic                    padding_read,
	input  logic                    layer_done,
	output word_t                   pixel_0,
	output logic                    pixel_0_valid,
	output word_t                   pixel_1,
	output logic                    pixel_1_valid,
	output word_t                   pixel_2,
	output logic                    pixel_2_valid,
	output word_t                   host_rdata,
	output logic                    padding_state
);

	logic [LDM_NUM_BITS-1:0] ctrl_bank_a_q, ctrl_bank_b_q, host_bank_q;
	logic                    ctrl_a_grant_q, ctrl_b_grant_q, host_grant_q;
	logic                    padding_q;
	logic                    exe3_q;           // bank 3 read for pixel 2 pending
	logic                    padding_state_q;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			ctrl_bank_a_q   <= '0;
			ctrl_bank_b_q   <= '0;
			host_bank_q     <= '0;
			ctrl_a_grant_q  <= 1'b0;
			ctrl_b_grant_q  <= 1'b0;
			host_grant_q    <= 1'b0;
			padding_q       <= 1'b0;
			exe3_q          <= 1'b0;
			padding_state_q <= 1'b0;
			pixel_2         <= '0;
			pixel_2_valid   <= 1'b0;
		end else begin
			ctrl_bank_a_q  <= ctrl_bank_a;
			ctrl_bank_b_q  <= ctrl_bank_b;
			host_bank_q    <= host_bank;
			ctrl_a_grant_q <= ctrl_a_grant;
			ctrl_b_grant_q <= ctrl_b_grant;
			host_grant_q   <= host_grant;
			padding_q      <= padding_read;
			exe3_q         <= (cfg_op == OP_EXE_ADD) && ctrl_a_grant;
			if (layer_done) begin
				padding_state_q <= 1'b0;   // end of layer wins
			end else if (padding_read) begin
				padding_state_q <= 1'b1;
			end
			pixel_2       <= exe3_q ? bank_rdata_a[LDM_NUM-1] : '0;
			pixel_2_valid <= exe3_q;
		end
	end

	// padding zeroes the stream picked by stride
	assign pixel_0       = (padding_q && !stride) ? '0 : bank_rdata_a[ctrl_bank_a_q];
	assign pixel_1       = (padding_q && stride) ? '0 : bank_rdata_b[ctrl_bank_b_q];
	assign pixel_0_valid = ctrl_a_grant_q;
	assign pixel_1_valid = ctrl_b_grant_q;

	assign host_rdata    = host_grant_q ? bank_rdata_a[host_bank_q] : '0;
	assign padding_state = !layer_done && (padding_state_q || padding_read);

endmodule

`default_nettype wire

/* design/lsu.sv */
// ========================================
// Load/store unit top with four dual-port data banks.
// Host and controller A share port A, ALU and controller B share port B.
// ========================================
`default_nettype none

module lsu import lsu_pkg::*; (
	input  logic                      CLK,
	input  logic                      RST,
	input  logic [FULL_ADDR_BITS-1:0] host_addr,
	input  word_t                     host_wdata,
	input  logic                      host_en,
	input  logic                      host_we,
	output word_t                     host_rdata,
	input  logic [FULL_ADDR_BITS-1:0] ctrl_addr_a,
	input  logic                      ctrl_en_a,
	input  logic [FULL_ADDR_BITS-1:0] ctrl_addr_b,
	input  logic                      ctrl_en_b,
	input  logic [FULL_ADDR_BITS-1:0] alu_addr,
	input  word_t                     alu_wdata,
	input  logic                      alu_en,
	input  logic                      alu_we,
	input  alu_op_e                   cfg_op,
	input  logic                      stride,
	input  logic                      padding_read,
	input  logic                      layer_done,
	output word_t                     pixel_0,
	output logic                      pixel_0_valid,
	output word_t                     pixel_1,
	output logic                      pixel_1_valid,
	output word_t                     pixel_2,
	output logic                      pixel_2_valid,
	output logic                      padding_state
);

	logic [LDM_NUM-1:0]                    bank_en_a, bank_we_a, bank_en_b, bank_we_b;
	logic [LDM_NUM-1:0][LDM_ADDR_BITS-1:0] bank_addr_a, bank_addr_b;
	word_t [LDM_NUM-1:0]                   bank_wdata_a, bank_wdata_b;
	word_t [LDM_NUM-1:0]                   bank_rdata_a, bank_rdata_b;
	logic                                  ctrl_a_grant, ctrl_b_grant, host_grant;

	ldm_port_router u_router (
		.host_addr    (host_addr),
		.host_wdata   (host_wdata),
		.host_en      (host_en),
		.host_we      (host_we),
		.ctrl_addr_a  (ctrl_addr_a),
		.ctrl_en_a    (ctrl_en_a),
		.ctrl_addr_b  (ctrl_addr_b),
		.ctrl_en_b    (ctrl_en_b),
		.alu_addr     (alu_addr),
		.alu_wdata    (alu_wdata),
		.alu_en       (alu_en),
		.alu_we       (alu_we),
		.cfg_op       (cfg_op),
		.bank_en_a    (bank_en_a),
		.bank_we_a    (bank_we_a),
		.bank_addr_a  (bank_addr_a),
		.bank_wdata_a (bank_wdata_a),
		.bank_en_b    (bank_en_b),
		.bank_we_b    (bank_we_b),
		.bank_addr_b  (bank_addr_b),
		.bank_wdata_b (bank_wdata_b),
		.ctrl_a_grant (ctrl_a_grant),
		.ctrl_b_grant (ctrl_b_grant),
		.host_grant   (host_grant)
	);

	for (genvar k = 0; k < LDM_NUM; k++) begin : gen_bank
		ldm_bank u_bank (
			.CLK     (CLK),
			.en_a    (bank_en_a[k]),
			.we_a    (bank_we_a[k]),
			.addr_a  (bank_addr_a[k]),
			.wdata_a (bank_wdata_a[k]),
			.en_b    (bank_en_b[k]),
			.we_b    (bank_we_b[k]),
			.addr_b  (bank_addr_b[k]),
			.wdata_b (bank_wdata_b[k]),
			.rdata_a (bank_rdata_a[k]),
			.rdata_b (bank_rdata_b[k])
		);
	end

	pixel_read_steer u_steer (
		.CLK           (CLK),
		.RST           (RST),
		.bank_rdata_a  (bank_rdata_a),
		.bank_rdata_b  (bank_rdata_b),
		.ctrl_bank_a   (ctrl_addr_a[FULL_ADDR_BITS-1:LDM_ADDR_BITS]),
		.ctrl_bank_b   (ctrl_addr_b[FULL_ADDR_BITS-1:LDM_ADDR_BITS]),
		.host_bank     (host_addr[FULL_ADDR_BITS-1:LDM_ADDR_BITS]),
		.ctrl_a_grant  (ctrl_a_grant),
		.ctrl_b_grant  (ctrl_b_grant),
		.host_grant    (host_grant),
		.cfg_op        (cfg_op),
		.stride        (stride),
		.padding_read  (padding_read),
		.layer_done    (layer_done),
		.pixel_0       (pixel_0),
		.pixel_0_valid (pixel_0_valid),
		.pixel_1       (pixel_1),
		.pixel_1_valid (pixel_1_valid),
		.pixel_2       (pixel_2),
		.pixel_2_valid (pixel_2_valid),
		.host_rdata    (host_rdata),
		.padding_state (padding_state)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// ========================================
// Clock and reset source for the testbench.
// ========================================
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic RST
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 4;   // 8 ns clock

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	initial begin
		RST = 1'b0;
		repeat (4) @(posedge CLK);
		RST <= 1'b1;   // released on the fourth edge
	end

endmodule

`default_nettype wire

/* testbench/lsu_assertions.sv */
// ========================================
// Concurrent checks on the load/store unit, bound into the top level.
// ========================================
`default_nettype none

module lsu_assertions import lsu_pkg::*; (
	input logic                                  CLK,
	input logic                                  RST,
	input logic [LDM_NUM-1:0]                    bank_we_a,
	input logic [LDM_NUM-1:0]                    bank_we_b,
	input logic [LDM_NUM-1:0][LDM_ADDR_BITS-1:0] bank_addr_a,
	input logic [LDM_NUM-1:0][LDM_ADDR_BITS-1:0] bank_addr_b,
	input logic                                  layer_done,
	input logic                                  padding_read,
	input logic                                  padding_state,
	input alu_op_e                               cfg_op,
	input logic                                  pixel_2_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [LDM_NUM-1:0] write_clash;   // one bit per bank

	always_comb begin
		for (int k = 0; k < LDM_NUM; k++) begin
			write_clash[k] = bank_we_a[k] && bank_we_b[k] &&
				(bank_addr_a[k] == bank_addr_b[k]);
		end
	end

	no_write_clash: assert property (@(posedge CLK) disable iff (!RST)
		write_clash == '0)
		else $error("both ports of a bank write the same word");

	// a fresh padding read may raise the state again right away
	layer_clears_padding: assert property (@(posedge CLK) disable iff (!RST)
		layer_done |=> (!padding_state || padding_read))
		else $error("padding state still high after layer done");

	pixel_2_from_exe_add: assert property (@(posedge CLK) disable iff (!RST)
		pixel_2_valid |-> ($past(cfg_op, 2) == OP_EXE_ADD))
		else $error("pixel 2 valid without an EXE_ADD read two cycles earlier");

endmodule

`default_nettype wire

/* testbench/tb_lsu.sv */
// ========================================
// Testbench for the load/store unit, one operation per line of testbench/lsu_input.txt.
// Columns: id kind (decimal), addr_x addr_y data exp_x exp_y (hex).
// ========================================
`default_nettype none

module tb_lsu import lsu_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_TIMEOUT  = 50;   // cycles
	localparam int MAX_LINES      = 200;
	localparam int K_RESET_CHECK  = 0;
	localparam int K_HOST_WR      = 1;
	localparam int K_HOST_RD      = 2;
	localparam int K_ALU_WR       = 3;
	localparam int K_CTRL_RD      = 4;    // both controller streams
	localparam int K_HOST_VS_CTRL = 5;    // addr_x host, addr_y controller A
	localparam int K_ALU_VS_CTRL  = 6;    // addr_x ALU write, addr_y controller B
	localparam int K_PAD_RD       = 7;    // stride from data bit 0
	localparam int K_LAYER_DONE   = 8;
	localparam int K_EXE_ADD      = 9;

	logic                      CLK;
	logic                      RST;
	logic [FULL_ADDR_BITS-1:0] host_addr;
	word_t                     host_wdata;
	logic                      host_en;
	logic                      host_we;
	word_t                     host_rdata;
	logic [FULL_ADDR_BITS-1:0] ctrl_addr_a;
	logic                      ctrl_en_a;
	logic [FULL_ADDR_BITS-1:0] ctrl_addr_b;
	logic                      ctrl_en_b;
	logic [FULL_ADDR_BITS-1:0] alu_addr;
	word_t                     alu_wdata;
	logic                      alu_en;
	logic                      alu_we;
	alu_op_e                   cfg_op;
	logic                      stride;
	logic                      padding_read;
	logic                      layer_done;
	word_t                     pixel_0;
	logic                      pixel_0_valid;
	word_t                     pixel_1;
	logic                      pixel_1_valid;
	word_t                     pixel_2;
	logic                      pixel_2_valid;
	logic                      padding_state;

	int                        seed;
	int                        err_count;
	int                        tests_run;
	int                        tests_failed;
	int                        fd;
	int                        code;
	int                        line_count;
	int                        waited;
	int                        id;
	int                        kind;
	logic [FULL_ADDR_BITS-1:0] addr_x;
	logic [FULL_ADDR_BITS-1:0] addr_y;
	logic [WORD_BITS-1:0]      data;
	logic [WORD_BITS-1:0]      exp_x;
	logic [WORD_BITS-1:0]      exp_y;

	tb_clock_gen u_clk (
		.CLK (CLK),
		.RST (RST)
	);

	lsu u_dut (
		.CLK           (CLK),
		.RST           (RST),
		.host_addr     (host_addr),
		.host_wdata    (host_wdata),
		.host_en       (host_en),
		.host_we       (host_we),
		.host_rdata    (host_rdata),
		.ctrl_addr_a   (ctrl_addr_a),
		.ctrl_en_a     (ctrl_en_a),
		.ctrl_addr_b   (ctrl_addr_b),
		.ctrl_en_b     (ctrl_en_b),
		.alu_addr      (alu_addr),
		.alu_wdata     (alu_wdata),
		.alu_en        (alu_en),
		.alu_we        (alu_we),
		.cfg_op        (cfg_op),
		.stride        (stride),
		.padding_read  (padding_read),
		.layer_done    (layer_done),
		.pixel_0       (pixel_0),
		.pixel_0_valid (pixel_0_valid),
		.pixel_1       (pixel_1),
		.pixel_1_valid (pixel_1_valid),
		.pixel_2       (pixel_2),
		.pixel_2_valid (pixel_2_valid),
		.padding_state (padding_state)
	);

	bind lsu lsu_assertions u_assertions (
		.CLK           (CLK),
		.RST           (RST),
		.bank_we_a     (bank_we_a),
		.bank_we_b     (bank_we_b),
		.bank_addr_a   (bank_addr_a),
		.bank_addr_b   (bank_addr_b),
		.layer_done    (layer_done),
		.padding_read  (padding_read),
		.padding_state (padding_state),
		.cfg_op        (cfg_op),
		.pixel_2_valid (pixel_2_valid)
	);

	function automatic string op_name(input int k);
		case (k)
			K_RESET_CHECK:  return "reset values";
			K_HOST_WR:      return "host write";
			K_HOST_RD:      return "host read";
			K_ALU_WR:       return "alu write";
			K_CTRL_RD:      return "controller read";
			K_HOST_VS_CTRL: return "host over controller a";
			K_ALU_VS_CTRL:  return "alu over controller b";
			K_PAD_RD:       return "padding read";
			K_LAYER_DONE:   return "layer done";
			K_EXE_ADD:      return "exe_add read";
			default:        return "unknown";
		endcase
	endfunction

	task automatic check_value(input string sig, input logic [WORD_BITS-1:0] got,
			input logic [WORD_BITS-1:0] expected);
		if (got !== expected) begin
			$display("FAILED %s got %h expected %h", sig, got, expected);
			err_count++;
		end
	endtask

	task automatic drive_idle();
		host_en      <= 1'b0;
		host_we      <= 1'b0;
		ctrl_en_a    <= 1'b0;
		ctrl_en_b    <= 1'b0;
		alu_en       <= 1'b0;
		alu_we       <= 1'b0;
		cfg_op       <= OP_NOP;
		padding_read <= 1'b0;
		layer_done   <= 1'b0;
		host_wdata   <= word_t'($random(seed));   // noise on unused data
		alu_wdata    <= word_t'($random(seed));
	endtask

	task automatic drive_op(input int k, input logic [FULL_ADDR_BITS-1:0] ax,
			input logic [FULL_ADDR_BITS-1:0] ay, input logic [WORD_BITS-1:0] d);
		case (k)
			K_HOST_WR: begin
				host_en    <= 1'b1;
				host_we    <= 1'b1;
				host_addr  <= ax;
				host_wdata <= d;
			end
			K_HOST_RD: begin
				host_en   <= 1'b1;
				host_addr <= ax;
			end
			K_ALU_WR: begin
				alu_en    <= 1'b1;
				alu_we    <= 1'b1;
				alu_addr  <= ax;
				alu_wdata <= d;
			end
			K_CTRL_RD, K_PAD_RD: begin
				ctrl_en_a   <= 1'b1;
				ctrl_addr_a <= ax;
				ctrl_en_b   <= 1'b1;
				ctrl_addr_b <= ay;
				if (k == K_PAD_RD) begin
					padding_read <= 1'b1;
					stride       <= d[0];
				end
			end
			K_HOST_VS_CTRL: begin
				host_en     <= 1'b1;
				host_addr   <= ax;
				ctrl_en_a   <= 1'b1;
				ctrl_addr_a <= ay;   // same bank as the host
			end
			K_ALU_VS_CTRL: begin
				alu_en      <= 1'b1;
				alu_we      <= 1'b1;
				alu_addr    <= ax;
				alu_wdata   <= d;
				ctrl_en_b   <= 1'b1;
				ctrl_addr_b <= ay;
			end
			K_LAYER_DONE: layer_done <= 1'b1;
			K_EXE_ADD: begin
				cfg_op      <= OP_EXE_ADD;
				ctrl_en_a   <= 1'b1;
				ctrl_addr_a <= ax;
			end
			default: begin
				$display("unknown operation kind %0d in the stimulus file", k);
				err_count++;
			end
		endcase
	endtask

	// one cycle after the request edge
	task automatic check_results(input int k, input logic [WORD_BITS-1:0] ex,
			input logic [WORD_BITS-1:0] ey);
		case (k)
			K_HOST_RD: check_value("host_rdata", host_rdata, ex);
			K_CTRL_RD, K_PAD_RD: begin
				check_value("pixel_0", pixel_0, ex);
				check_value("pixel_0_valid", 16'(pixel_0_valid), 16'h0001);
				check_value("pixel_1", pixel_1, ey);
				check_value("pixel_1_valid", 16'(pixel_1_valid), 16'h0001);
				if (k == K_PAD_RD) begin
					check_value("padding_state", 16'(padding_state), 16'h0001);
				end
			end
			K_HOST_VS_CTRL: begin
				check_value("host_rdata", host_rdata, ex);
				check_value("pixel_0_valid", 16'(pixel_0_valid), 16'h0000);
			end
			K_ALU_VS_CTRL: check_value("pixel_1_valid", 16'(pixel_1_valid), 16'h0000);
			K_LAYER_DONE: check_value("padding_state", 16'(padding_state), 16'h0000);
			K_EXE_ADD: check_value("pixel_2_valid", 16'(pixel_2_valid), 16'h0000);
			default: ;
		endcase
	endtask

	task automatic run_test(input int tid, input int k, input logic [FULL_ADDR_BITS-1:0] ax,
			input logic [FULL_ADDR_BITS-1:0] ay, input logic [WORD_BITS-1:0] d,
			input logic [WORD_BITS-1:0] ex, input logic [WORD_BITS-1:0] ey);
		int errs_before;
		errs_before = err_count;
		if (k == K_RESET_CHECK) begin
			check_value("pixel_0_valid", 16'(pixel_0_valid), 16'h0000);
			check_value("pixel_1_valid", 16'(pixel_1_valid), 16'h0000);
			check_value("pixel_2_valid", 16'(pixel_2_valid), 16'h0000);
			check_value("pixel_2", pixel_2, 16'h0000);
			check_value("host_rdata", host_rdata, 16'h0000);
			check_value("padding_state", 16'(padding_state), 16'h0000);
		end else begin
			if (k == K_LAYER_DONE) begin
				check_value("padding_state", 16'(padding_state), 16'(ex[0]));
			end
			@(posedge CLK);
			drive_op(k, ax, ay, d);
			@(negedge CLK);
			if (k == K_LAYER_DONE) begin
				check_value("padding_state", 16'(padding_state), 16'h0000);   // drops at once
			end
			@(posedge CLK);
			drive_idle();
			@(negedge CLK);
			check_results(k, ex, ey);
			if (k == K_EXE_ADD) begin
				@(posedge CLK);
				@(negedge CLK);
				check_value("pixel_2", pixel_2, ex);
				check_value("pixel_2_valid", 16'(pixel_2_valid), 16'h0001);
			end
		end
		tests_run++;
		if (err_count == errs_before) begin
			$display("test %0d %s: ok", tid, op_name(k));
		end else begin
			tests_failed++;
			$display("test %0d %s: FAIL", tid, op_name(k));
		end
	endtask

	initial begin
		seed         = 32'h6ffc_2e34;
		err_count    = 0;
		tests_run    = 0;
		tests_failed = 0;
		host_addr    = '0;
		host_wdata   = '0;
		host_en      = 1'b0;
		host_we      = 1'b0;
		ctrl_addr_a  = '0;
		ctrl_en_a    = 1'b0;
		ctrl_addr_b  = '0;
		ctrl_en_b    = 1'b0;
		alu_addr     = '0;
		alu_wdata    = '0;
		alu_en       = 1'b0;
		alu_we       = 1'b0;
		cfg_op       = OP_NOP;
		stride       = 1'b0;
		padding_read = 1'b0;
		layer_done   = 1'b0;

		waited = 0;
		while (RST !== 1'b1 && waited < RESET_TIMEOUT) begin
			@(negedge CLK);
			waited++;
		end
		if (RST !== 1'b1) begin
			$display("reset was not released within %0d cycles", RESET_TIMEOUT);
			err_count++;
		end else begin
			fd = $fopen("testbench/lsu_input.txt", "r");
			if (fd == 0) begin
				$display("could not open the stimulus file");
				err_count++;
			end else begin
				line_count = 0;
				code       = 7;
				while (code == 7 && line_count < MAX_LINES) begin
					code = $fscanf(fd, "%d %d %h %h %h %h %h", id, kind,
						addr_x, addr_y, data, exp_x, exp_y);
					if (code == 7) begin
						run_test(id, kind, addr_x, addr_y, data, exp_x, exp_y);
						line_count++;
					end else if (!$feof(fd)) begin
						$display("malformed line after %0d operations in the stimulus file",
							line_count);
						err_count++;
					end
				end
				$fclose(fd);
				if (tests_run == 0) begin
					$display("no operations were read from the stimulus file");
					err_count++;
				end
			end
		end

		$display("summary: %0d run, %0d passed, %0d failed, %0d mismatches",
			tests_run, tests_run - tests_failed, tests_failed, err_count);
		if (err_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
design/lsu_pkg.sv
design/ldm_bank.sv
design/ldm_port_router.sv
design/pixel_read_steer.sv
design/lsu.sv
testbench/tb_clock_gen.sv
testbench/lsu_assertions.sv
testbench/tb_lsu.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the load/store unit testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_lsu -f verilog.f -o sim_lsu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^all tests passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* testbench/lsu_input.txt */
1 0 00 00 0000 0000 0000
2 1 05 00 1234 0000 0000
3 1 4a 00 abcd 0000 0000
4 2 05 00 0000 1234 0000
5 2 4a 00 0000 abcd 0000
6 3 90 00 5a5a 0000 0000
7 1 90 00 ffff 0000 0000
8 2 90 00 0000 5a5a 0000
9 3 01 00 1111 0000 0000
10 3 42 00 2222 0000 0000
11 3 83 00 3333 0000 0000
12 3 c4 00 4444 0000 0000
13 4 01 c4 0000 1111 4444
14 4 42 83 0000 2222 3333
15 5 05 01 0000 1234 0000
16 6 42 43 7777 0000 0000
17 4 42 83 0000 7777 3333
18 7 01 c4 0000 0000 4444
19 7 01 c4 0001 1111 0000
20 8 00 00 0000 0001 0000
21 3 c7 00 9abc 0000 0000
22 9 c4 00 0000 4444 0000
23 9 07 00 0000 9abc 0000
